// ==== bench/core_stimulus.txt ====
// columns: test  instruction  expected rd  expected value
// all fields hex, one instruction per line in program order
1 24010005 01 00000005 // addiu r1, r0, 5
1 2402000c 02 0000000c // addiu r2, r0, 12
1 3c031234 03 12340000 // lui   r3, 0x1234
1 340400f0 04 000000f0 // ori   r4, r0, 0xf0
1 00222821 05 00000011 // addu  r5, r1, r2
1 00413023 06 00000007 // subu  r6, r2, r1
1 00643826 07 123400f0 // xor   r7, r3, r4
1 00244025 08 000000f5 // or    r8, r1, r4
2 24090100 09 00000100 // addiu r9, r0, 0x100
2 01294821 09 00000200 // addu  r9, r9, r9
2 252affff 0a 000001ff // addiu r10, r9, -1
2 0149582a 0b 00000001 // slt   r11, r10, r9
2 356c8000 0c 00008001 // ori   r12, r11, 0x8000
2 018a6824 0d 00000001 // and   r13, r12, r10
3 240e0001 0e 00000001 // addiu r14, r0, 1
3 01ce7021 0e 00000002 // addu  r14, r14, r14
3 01ce7021 0e 00000004 // addu  r14, r14, r14
3 01ce7021 0e 00000008 // addu  r14, r14, r14
3 25ce0003 0e 0000000b // addiu r14, r14, 3
3 01c17823 0f 00000006 // subu  r15, r14, r1
3 01ee7026 0e 0000000d // xor   r14, r15, r14
3 01ce8021 10 0000001a // addu  r16, r14, r14
4 24000055 00 00000055 // addiu r0, r0, 0x55
4 3411ffff 11 0000ffff // ori   r17, r0, 0xffff
4 00119021 12 0000ffff // addu  r18, r0, r17
4 24138000 13 ffff8000 // addiu r19, r0, 0x8000
4 3c14abcd 14 abcd0000 // lui   r20, 0xabcd
4 36941234 14 abcd1234 // ori   r20, r20, 0x1234
4 00000000 00 00000000 // nop
4 0260a82a 15 00000001 // slt   r21, r19, r0
4 02310021 00 0001fffe // addu  r0, r17, r17
4 0014b025 16 abcd1234 // or    r22, r0, r20
5 24170001 17 00000001 // addiu r23, r0, 1
5 26f70003 17 00000004 // addiu r23, r23, 3
5 26f70003 17 00000007
5 26f70003 17 0000000a
5 26f70003 17 0000000d
5 26f70003 17 00000010
5 26f70003 17 00000013
5 26f70003 17 00000016
5 26f70003 17 00000019
5 26f70003 17 0000001c
5 02f7c021 18 00000038 // addu  r24, r23, r23

// ==== bench/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core;

localparam int MAX_LINES  = 64;
localparam int FIELDS     = 4;
localparam int BURST_TEST = 5;

logic                         clk;
logic                         reset_i;
logic                   [1:0] fetch_valid_i;
core_pkg::instr_t       [1:0] fetch_instr_i;
core_pkg::issue_count_t       fetch_ack_o;
logic                         commit_valid_o;
core_pkg::reg_addr_t          commit_rd_o;
core_pkg::uint32_t            commit_data_o;

logic                [31:0] stim       [MAX_LINES * FIELDS];
int                         test_id    [MAX_LINES];
core_pkg::instr_t           instr_word [MAX_LINES];
core_pkg::reg_addr_t        exp_rd     [MAX_LINES];
core_pkg::uint32_t          exp_data   [MAX_LINES];

int     num_instr      = 0;
int     fetch_idx      = 0;
int     ack_seen       = 0;
int     exp_idx        = 0;
int     cycle_count    = 0;
int     cycle_limit    = 0;
int     error_count    = 0;
int     test_errors    = 0;
int     test_commits   = 0;
int     tests_passed   = 0;
int     tests_failed   = 0;
int     stall_cycles   = 0;
int     burst_stalls   = 0;
logic   timed_out      = 1'b0;
integer seed           = 41;

core_top u_dut (
	.clk            ( clk            ),
	.reset_i        ( reset_i        ),
	.fetch_valid_i  ( fetch_valid_i  ),
	.fetch_instr_i  ( fetch_instr_i  ),
	.fetch_ack_o    ( fetch_ack_o    ),
	.commit_valid_o ( commit_valid_o ),
	.commit_rd_o    ( commit_rd_o    ),
	.commit_data_o  ( commit_data_o  )
);

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

function automatic string test_name(input int id);
	case (id)
		1: return "independent pairs";
		2: return "intra-packet dependency";
		3: return "chains and register reuse";
		4: return "r0 and immediates";
		5: return "back-pressure burst";
		default: return "unnamed";
	endcase
endfunction

// four words per instruction, all ones marks the end
task automatic load_stimulus();
	for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
		stim[i] = '1;
	end
	$readmemh("bench/core_stimulus.txt", stim);
	while (num_instr < MAX_LINES && stim[num_instr * FIELDS] != 32'hffffffff) begin
		test_id[num_instr]    = int'(stim[num_instr * FIELDS]);
		instr_word[num_instr] = stim[num_instr * FIELDS + 1];
		exp_rd[num_instr]     = stim[num_instr * FIELDS + 2][4:0];
		exp_data[num_instr]   = stim[num_instr * FIELDS + 3];
		num_instr++;
	end
endtask

// front of the queue in slot 0, slot 1 sometimes left empty
task automatic drive_fetch();
	logic [31:0] rnd;
	rnd = $random(seed);
	if (fetch_idx < num_instr) begin
		fetch_valid_i[0] <= 1'b1;
		fetch_instr_i[0] <= instr_word[fetch_idx];
	end else begin
		fetch_valid_i[0] <= 1'b0;
		fetch_instr_i[0] <= '0;
	end
	if (fetch_idx + 1 < num_instr && rnd[1:0] != 2'b00) begin
		fetch_valid_i[1] <= 1'b1;
		fetch_instr_i[1] <= instr_word[fetch_idx + 1];
	end else begin
		fetch_valid_i[1] <= 1'b0;
		fetch_instr_i[1] <= '0;
	end
endtask

task automatic finish_test(input int id);
	if (test_errors == 0) begin
		tests_passed++;
	end else begin
		tests_failed++;
	end
	$display("test %0d (%s): %0d commits, %0d errors", id, test_name(id), test_commits,
		test_errors);
	error_count  = error_count + test_errors;
	test_errors  = 0;
	test_commits = 0;
endtask

task automatic check_commit();
	if (exp_idx >= num_instr) begin
		$display("unexpected extra commit to r%0d after all instructions had committed",
			commit_rd_o);
		error_count++;
	end else begin
		if (commit_rd_o !== exp_rd[exp_idx]) begin
			$display("[FAIL] instr %0d: commit_rd_o = 0x%02h, expected 0x%02h",
				exp_idx, commit_rd_o, exp_rd[exp_idx]);
			test_errors++;
		end
		if (commit_data_o !== exp_data[exp_idx]) begin
			$display("[FAIL] instr %0d: commit_data_o = 0x%08h, expected 0x%08h",
				exp_idx, commit_data_o, exp_data[exp_idx]);
			test_errors++;
		end
		test_commits++;
		exp_idx++;
		if (exp_idx == num_instr || test_id[exp_idx] != test_id[exp_idx - 1]) begin
			finish_test(test_id[exp_idx - 1]);
		end
	end
endtask

// outputs are settled half a cycle after the edge
always @(negedge clk) begin
	if (!reset_i && commit_valid_o) begin
		check_commit();
	end
end

initial begin
	reset_i       = 1'b1;
	fetch_valid_i = '0;
	fetch_instr_i = '0;
	load_stimulus();
	if (num_instr == 0) begin
		$display("no instructions were read from the stimulus file");
		error_count++;
	end
	cycle_limit = 20 * num_instr + 100;
	repeat (5) @(posedge clk);
	reset_i <= 1'b0;

	while (exp_idx < num_instr && !timed_out) begin
		@(posedge clk);
		fetch_idx = fetch_idx + ack_seen;
		drive_fetch();
		@(negedge clk);
		ack_seen = int'(fetch_ack_o);
		if (fetch_valid_i[0] && ack_seen < int'(fetch_valid_i[0]) + int'(fetch_valid_i[1])) begin
			stall_cycles++;
			if (test_id[fetch_idx] == BURST_TEST) burst_stalls++;
		end
		cycle_count++;
		if (cycle_count >= cycle_limit) timed_out = 1'b1;
	end

	if (timed_out) begin
		$display("timeout: %0d of %0d instructions committed after %0d cycles",
			exp_idx, num_instr, cycle_count);
		error_count++;
	end else begin
		// any duplicate commit would show up here
		repeat (10) @(negedge clk);
		if (burst_stalls == 0 && num_instr > 0) begin
			$display("fetch_ack_o never dropped during the back-pressure burst");
			error_count++;
		end
	end

	$display("%0d tests passed, %0d tests failed, %0d errors, %0d of %0d commits, %0d stalls",
		tests_passed, tests_failed, error_count, exp_idx, num_instr, stall_cycles);
	if (error_count == 0) begin
		$display("Simulation finished: PASS");
	end else begin
		$display("Simulation finished: FAIL");
	end
	$finish;
end

endmodule

`default_nettype wire

// ==== rtl/alu_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_station (
	input  logic                            clk,
	input  logic                            reset_i,
	input  logic                      [1:0] rs_write_i,
	input  core_pkg::rs_index_t       [1:0] rs_write_index_i,
	input  core_pkg::alu_op_t         [1:0] rs_op_i,
	input  core_pkg::uint32_t    [1:0][1:0] rs_opnd_i,
	input  logic                 [1:0][1:0] rs_opnd_ready_i,
	input  core_pkg::rob_index_t [1:0][1:0] rs_opnd_tag_i,
	input  core_pkg::rob_index_t      [1:0] rs_dest_tag_i,
	output logic                      [1:0] rs_free_o,
	output core_pkg::rs_index_t       [1:0] rs_free_index_o,
	output logic                            cdb_valid_o,
	output core_pkg::rob_index_t            cdb_tag_o,
	output core_pkg::uint32_t               cdb_data_o
);

logic [core_pkg::RS_COUNT-1:0] valid;
core_pkg::alu_op_t             op    [core_pkg::RS_COUNT];
core_pkg::uint32_t       [1:0] opnd  [core_pkg::RS_COUNT];
logic                    [1:0] ready [core_pkg::RS_COUNT];
core_pkg::rob_index_t    [1:0] tag   [core_pkg::RS_COUNT];
core_pkg::rob_index_t          dest  [core_pkg::RS_COUNT];
logic                    [2:0] age   [core_pkg::RS_COUNT];
logic                          sel_valid;
core_pkg::rs_index_t           sel_index;
core_pkg::uint32_t             opnd_a;
core_pkg::uint32_t             opnd_b;
core_pkg::uint32_t             result;

// lowest two free entries
always_comb begin
	rs_free_o       = '0;
	rs_free_index_o = '0;
	for (int i = 0; i < core_pkg::RS_COUNT; i++) begin
		if (!valid[i] && !rs_free_o[0]) begin
			rs_free_o[0]       = 1'b1;
			rs_free_index_o[0] = core_pkg::rs_index_t'(i);
		end else if (!valid[i] && !rs_free_o[1]) begin
			rs_free_o[1]       = 1'b1;
			rs_free_index_o[1] = core_pkg::rs_index_t'(i);
		end
	end
end

// oldest ready entry, lower index on equal age
always_comb begin
	sel_valid = 1'b0;
	sel_index = '0;
	for (int i = 0; i < core_pkg::RS_COUNT; i++) begin
		if (valid[i] && ready[i] == 2'b11 && (!sel_valid || age[i] > age[sel_index])) begin
			sel_valid = 1'b1;
			sel_index = core_pkg::rs_index_t'(i);
		end
	end
end

assign opnd_a = opnd[sel_index][0];
assign opnd_b = opnd[sel_index][1];

always_comb begin
	case (op[sel_index])
		core_pkg::ALU_ADD: result = opnd_a + opnd_b;
		core_pkg::ALU_SUB: result = opnd_a - opnd_b;
		core_pkg::ALU_AND: result = opnd_a & opnd_b;
		core_pkg::ALU_OR:  result = opnd_a | opnd_b;
		core_pkg::ALU_XOR: result = opnd_a ^ opnd_b;
		core_pkg::ALU_SLT: result = {31'h0, $signed(opnd_a) < $signed(opnd_b)};
		core_pkg::ALU_LUI: result = {opnd_b[15:0], 16'h0};
		default:           result = '0;
	endcase
end

always_ff @(posedge clk) begin
	if (reset_i) begin
		valid       <= '0;
		cdb_valid_o <= 1'b0;
	end else begin
		cdb_valid_o <= sel_valid;
		if (sel_valid) valid[sel_index] <= 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (rs_write_i[w]) valid[rs_write_index_i[w]] <= 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	cdb_tag_o  <= dest[sel_index];
	cdb_data_o <= result;
	for (int i = 0; i < core_pkg::RS_COUNT; i++) begin
		if (age[i] != 3'd7) age[i] <= age[i] + 3'd1;
		// snoop the cdb for waiting operands
		for (int j = 0; j < 2; j++) begin
			if (cdb_valid_o && !ready[i][j] && tag[i][j] == cdb_tag_o) begin
				opnd[i][j]  <= cdb_data_o;
				ready[i][j] <= 1'b1;
			end
		end
	end
	for (int w = 0; w < 2; w++) begin
		if (rs_write_i[w]) begin
			op[rs_write_index_i[w]]    <= rs_op_i[w];
			opnd[rs_write_index_i[w]]  <= rs_opnd_i[w];
			ready[rs_write_index_i[w]] <= rs_opnd_ready_i[w];
			tag[rs_write_index_i[w]]   <= rs_opnd_tag_i[w];
			dest[rs_write_index_i[w]]  <= rs_dest_tag_i[w];
			// slot 0 is older than slot 1
			age[rs_write_index_i[w]]   <= (w == 0) ? 3'd1 : 3'd0;
		end
	end
end

endmodule

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

	localparam int ROB_DEPTH = 8;
	localparam int RS_COUNT  = 4;

	typedef logic [31:0] uint32_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [2:0]  rob_index_t;
	typedef logic [1:0]  rs_index_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [1:0]  issue_count_t;

	// alu operations
	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR  = 4'd3;
	localparam alu_op_t ALU_XOR = 4'd4;
	localparam alu_op_t ALU_SLT = 4'd5;
	localparam alu_op_t ALU_LUI = 4'd6;

	// major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	// funct field of OP_SPECIAL
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

`default_nettype wire

// ==== rtl/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top (
	input  logic                         clk,
	input  logic                         reset_i,
	input  logic                   [1:0] fetch_valid_i,
	input  core_pkg::instr_t       [1:0] fetch_instr_i,
	output core_pkg::issue_count_t       fetch_ack_o,
	output logic                         commit_valid_o,
	output core_pkg::reg_addr_t          commit_rd_o,
	output core_pkg::uint32_t            commit_data_o
);

core_pkg::reg_addr_t            [3:0] reg_raddr;
core_pkg::uint32_t              [3:0] reg_rdata;
logic                           [3:0] reg_busy;
core_pkg::rob_index_t           [3:0] reg_tag;
logic                           [1:0] status_we;
core_pkg::reg_addr_t            [1:0] status_waddr;
core_pkg::rob_index_t           [1:0] status_tag;
logic                           [3:0] rob_free_count;
core_pkg::rob_index_t           [1:0] rob_tag;
core_pkg::rob_index_t           [3:0] rob_query_tag;
logic                           [3:0] rob_query_ready;
core_pkg::uint32_t              [3:0] rob_query_data;
logic                           [1:0] rob_alloc;
core_pkg::reg_addr_t            [1:0] rob_alloc_rd;
logic                           [1:0] rs_free;
core_pkg::rs_index_t            [1:0] rs_free_index;
logic                           [1:0] rs_write;
core_pkg::rs_index_t            [1:0] rs_write_index;
core_pkg::alu_op_t              [1:0] rs_op;
core_pkg::uint32_t         [1:0][1:0] rs_opnd;
logic                      [1:0][1:0] rs_opnd_ready;
core_pkg::rob_index_t      [1:0][1:0] rs_opnd_tag;
core_pkg::rob_index_t           [1:0] rs_dest_tag;
logic                                 cdb_valid;
core_pkg::rob_index_t                 cdb_tag;
core_pkg::uint32_t                    cdb_data;
core_pkg::rob_index_t                 commit_tag;

instr_issue u_issue (
	.fetch_valid_i,
	.fetch_instr_i,
	.fetch_ack_o,
	.reg_raddr_o        ( reg_raddr       ),
	.reg_rdata_i        ( reg_rdata       ),
	.reg_busy_i         ( reg_busy        ),
	.reg_tag_i          ( reg_tag         ),
	.rob_free_count_i   ( rob_free_count  ),
	.rob_tag_i          ( rob_tag         ),
	.rob_query_tag_o    ( rob_query_tag   ),
	.rob_query_ready_i  ( rob_query_ready ),
	.rob_query_data_i   ( rob_query_data  ),
	.rob_alloc_o        ( rob_alloc       ),
	.rob_alloc_rd_o     ( rob_alloc_rd    ),
	.rs_free_i          ( rs_free         ),
	.rs_free_index_i    ( rs_free_index   ),
	.rs_write_o         ( rs_write        ),
	.rs_write_index_o   ( rs_write_index  ),
	.rs_op_o            ( rs_op           ),
	.rs_opnd_o          ( rs_opnd         ),
	.rs_opnd_ready_o    ( rs_opnd_ready   ),
	.rs_opnd_tag_o      ( rs_opnd_tag     ),
	.rs_dest_tag_o      ( rs_dest_tag     ),
	.cdb_valid_i        ( cdb_valid       ),
	.cdb_tag_i          ( cdb_tag         ),
	.cdb_data_i         ( cdb_data        ),
	.reg_status_we_o    ( status_we       ),
	.reg_status_waddr_o ( status_waddr    ),
	.reg_status_tag_o   ( status_tag      )
);

reg_file u_reg_file (
	.clk,
	.reset_i,
	.raddr_i        ( reg_raddr      ),
	.rdata_o        ( reg_rdata      ),
	.busy_o         ( reg_busy       ),
	.tag_o          ( reg_tag        ),
	.status_we_i    ( status_we      ),
	.status_waddr_i ( status_waddr   ),
	.status_tag_i   ( status_tag     ),
	.commit_valid_i ( commit_valid_o ),
	.commit_rd_i    ( commit_rd_o    ),
	.commit_tag_i   ( commit_tag     ),
	.commit_data_i  ( commit_data_o  )
);

alu_station u_alu_station (
	.clk,
	.reset_i,
	.rs_write_i       ( rs_write       ),
	.rs_write_index_i ( rs_write_index ),
	.rs_op_i          ( rs_op          ),
	.rs_opnd_i        ( rs_opnd        ),
	.rs_opnd_ready_i  ( rs_opnd_ready  ),
	.rs_opnd_tag_i    ( rs_opnd_tag    ),
	.rs_dest_tag_i    ( rs_dest_tag    ),
	.rs_free_o        ( rs_free        ),
	.rs_free_index_o  ( rs_free_index  ),
	.cdb_valid_o      ( cdb_valid      ),
	.cdb_tag_o        ( cdb_tag        ),
	.cdb_data_o       ( cdb_data       )
);

reorder_buffer u_rob (
	.clk,
	.reset_i,
	.alloc_i        ( rob_alloc       ),
	.alloc_rd_i     ( rob_alloc_rd    ),
	.free_count_o   ( rob_free_count  ),
	.next_tag_o     ( rob_tag         ),
	.query_tag_i    ( rob_query_tag   ),
	.query_ready_o  ( rob_query_ready ),
	.query_data_o   ( rob_query_data  ),
	.cdb_valid_i    ( cdb_valid       ),
	.cdb_tag_i      ( cdb_tag         ),
	.cdb_data_i     ( cdb_data        ),
	.commit_valid_o,
	.commit_rd_o,
	.commit_tag_o   ( commit_tag      ),
	.commit_data_o
);

endmodule

`default_nettype wire

// ==== rtl/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  core_pkg::instr_t    instr_i,
	output logic                valid_o,
	output core_pkg::alu_op_t   alu_op_o,
	output core_pkg::reg_addr_t rs_o,
	output core_pkg::reg_addr_t rt_o,
	output core_pkg::reg_addr_t rd_o,
	output logic                use_imm_o,
	output core_pkg::uint32_t   imm_o
);

logic [5:0] opcode;
logic [5:0] funct;

assign opcode = instr_i[31:26];
assign funct  = instr_i[5:0];
assign rs_o   = instr_i[25:21];
assign rt_o   = instr_i[20:16];

always_comb begin
	valid_o   = 1'b1;
	alu_op_o  = core_pkg::ALU_ADD;
	rd_o      = '0;
	use_imm_o = 1'b1;
	imm_o     = {{16{instr_i[15]}}, instr_i[15:0]};
	case (opcode)
		core_pkg::OP_SPECIAL: begin
			use_imm_o = 1'b0;
			rd_o      = instr_i[15:11];
			case (funct)
				core_pkg::FN_ADDU: alu_op_o = core_pkg::ALU_ADD;
				core_pkg::FN_SUBU: alu_op_o = core_pkg::ALU_SUB;
				core_pkg::FN_AND:  alu_op_o = core_pkg::ALU_AND;
				core_pkg::FN_OR:   alu_op_o = core_pkg::ALU_OR;
				core_pkg::FN_XOR:  alu_op_o = core_pkg::ALU_XOR;
				core_pkg::FN_SLT:  alu_op_o = core_pkg::ALU_SLT;
				default: begin
					// nop is the all-zero word, result goes to r0
					valid_o = (instr_i == '0);
					rd_o    = '0;
				end
			endcase
		end
		core_pkg::OP_ADDIU: rd_o = instr_i[20:16];
		core_pkg::OP_ORI: begin
			alu_op_o = core_pkg::ALU_OR;
			rd_o     = instr_i[20:16];
			imm_o    = {16'h0, instr_i[15:0]};
		end
		core_pkg::OP_LUI: begin
			alu_op_o = core_pkg::ALU_LUI;
			rd_o     = instr_i[20:16];
			imm_o    = {16'h0, instr_i[15:0]};
		end
		default: valid_o = 1'b0;
	endcase
end

endmodule

`default_nettype wire

// ==== rtl/dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatcher (
	input  logic                        valid_i,
	input  core_pkg::alu_op_t           alu_op_i,
	input  logic                        use_imm_i,
	input  core_pkg::uint32_t           imm_i,
	input  logic                  [1:0] src_busy_i,
	input  core_pkg::rob_index_t  [1:0] src_tag_i,
	input  core_pkg::uint32_t     [1:0] src_rdata_i,
	input  logic                  [1:0] rob_ready_i,
	input  core_pkg::uint32_t     [1:0] rob_data_i,
	input  logic                        cdb_valid_i,
	input  core_pkg::rob_index_t        cdb_tag_i,
	input  core_pkg::uint32_t           cdb_data_i,
	input  logic                        rs_free_i,
	input  logic                        stall_i,
	output logic                        write_o,
	output core_pkg::alu_op_t           op_o,
	output core_pkg::uint32_t     [1:0] opnd_o,
	output logic                  [1:0] opnd_ready_o,
	output core_pkg::rob_index_t  [1:0] opnd_tag_o
);

assign write_o    = valid_i & rs_free_i & ~stall_i;
assign op_o       = alu_op_i;
assign opnd_tag_o = src_tag_i;

always_comb begin
	for (int i = 0; i < 2; i++) begin
		opnd_o[i]       = '0;
		opnd_ready_o[i] = 1'b1;
		if (!src_busy_i[i]) begin
			opnd_o[i] = src_rdata_i[i];
		end else if (rob_ready_i[i]) begin
			// finished but not yet committed
			opnd_o[i] = rob_data_i[i];
		end else if (cdb_valid_i && cdb_tag_i == src_tag_i[i]) begin
			opnd_o[i] = cdb_data_i;
		end else begin
			opnd_ready_o[i] = 1'b0;
		end
	end
	// immediate takes the place of rt
	if (use_imm_i) begin
		opnd_o[1]       = imm_i;
		opnd_ready_o[1] = 1'b1;
	end
end

endmodule

`default_nettype wire

// ==== rtl/instr_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_issue (
	input  logic                            [1:0] fetch_valid_i,
	input  core_pkg::instr_t                [1:0] fetch_instr_i,
	output core_pkg::issue_count_t                fetch_ack_o,
	output core_pkg::reg_addr_t             [3:0] reg_raddr_o,
	input  core_pkg::uint32_t               [3:0] reg_rdata_i,
	input  logic                            [3:0] reg_busy_i,
	input  core_pkg::rob_index_t            [3:0] reg_tag_i,
	input  logic                            [3:0] rob_free_count_i,
	input  core_pkg::rob_index_t            [1:0] rob_tag_i,
	output core_pkg::rob_index_t            [3:0] rob_query_tag_o,
	input  logic                            [3:0] rob_query_ready_i,
	input  core_pkg::uint32_t               [3:0] rob_query_data_i,
	output logic                            [1:0] rob_alloc_o,
	output core_pkg::reg_addr_t             [1:0] rob_alloc_rd_o,
	input  logic                            [1:0] rs_free_i,
	input  core_pkg::rs_index_t             [1:0] rs_free_index_i,
	output logic                            [1:0] rs_write_o,
	output core_pkg::rs_index_t             [1:0] rs_write_index_o,
	output core_pkg::alu_op_t               [1:0] rs_op_o,
	output core_pkg::uint32_t          [1:0][1:0] rs_opnd_o,
	output logic                       [1:0][1:0] rs_opnd_ready_o,
	output core_pkg::rob_index_t       [1:0][1:0] rs_opnd_tag_o,
	output core_pkg::rob_index_t            [1:0] rs_dest_tag_o,
	input  logic                                  cdb_valid_i,
	input  core_pkg::rob_index_t                  cdb_tag_i,
	input  core_pkg::uint32_t                     cdb_data_i,
	output logic                            [1:0] reg_status_we_o,
	output core_pkg::reg_addr_t             [1:0] reg_status_waddr_o,
	output core_pkg::rob_index_t            [1:0] reg_status_tag_o
);

logic                           [1:0] dec_valid;
core_pkg::alu_op_t              [1:0] dec_op;
core_pkg::reg_addr_t            [1:0] dec_rs;
core_pkg::reg_addr_t            [1:0] dec_rt;
core_pkg::reg_addr_t            [1:0] dec_rd;
logic                           [1:0] dec_use_imm;
core_pkg::uint32_t              [1:0] dec_imm;
logic                           [1:0] slot_valid;
logic                           [1:0] slot_stall;
logic                           [1:0] write;
core_pkg::uint32_t         [1:0][1:0] disp_opnd;
logic                      [1:0][1:0] disp_ready;
core_pkg::rob_index_t      [1:0][1:0] disp_tag;
logic                                 stall;

// no room for even one instruction
assign stall = (rob_free_count_i == '0) | ~rs_free_i[0];

assign slot_valid[0] = fetch_valid_i[0];
assign slot_valid[1] = fetch_valid_i[1] & write[0];
assign slot_stall[0] = stall;
assign slot_stall[1] = stall | (rob_free_count_i < 4'd2);

for (genvar i = 0; i < 2; i++) begin : gen_slot
	decoder u_decoder (
		.instr_i   ( fetch_instr_i[i] ),
		.valid_o   ( dec_valid[i]     ),
		.alu_op_o  ( dec_op[i]        ),
		.rs_o      ( dec_rs[i]        ),
		.rt_o      ( dec_rt[i]        ),
		.rd_o      ( dec_rd[i]        ),
		.use_imm_o ( dec_use_imm[i]   ),
		.imm_o     ( dec_imm[i]       )
	);

	dispatcher u_dispatcher (
		.valid_i      ( slot_valid[i]                ),
		.alu_op_i     ( dec_op[i]                    ),
		.use_imm_i    ( dec_use_imm[i]               ),
		.imm_i        ( dec_imm[i]                   ),
		.src_busy_i   ( reg_busy_i[i * 2 +: 2]        ),
		.src_tag_i    ( reg_tag_i[i * 2 +: 2]         ),
		.src_rdata_i  ( reg_rdata_i[i * 2 +: 2]       ),
		.rob_ready_i  ( rob_query_ready_i[i * 2 +: 2] ),
		.rob_data_i   ( rob_query_data_i[i * 2 +: 2]  ),
		.cdb_valid_i,
		.cdb_tag_i,
		.cdb_data_i,
		.rs_free_i    ( rs_free_i[i]                 ),
		.stall_i      ( slot_stall[i]                ),
		.write_o      ( write[i]                     ),
		.op_o         ( rs_op_o[i]                   ),
		.opnd_o       ( disp_opnd[i]                 ),
		.opnd_ready_o ( disp_ready[i]                ),
		.opnd_tag_o   ( disp_tag[i]                  )
	);

	assign reg_raddr_o[i * 2]     = dec_rs[i];
	assign reg_raddr_o[i * 2 + 1] = dec_rt[i];
	assign reg_status_we_o[i]     = write[i] & dec_valid[i] & (dec_rd[i] != '0);
end

assign fetch_ack_o        = {1'b0, write[0]} + {1'b0, write[1]};
assign rob_query_tag_o    = reg_tag_i;
assign rob_alloc_o        = write;
assign rob_alloc_rd_o     = dec_rd;
assign rs_write_o         = write;
assign rs_write_index_o   = rs_free_index_i;
assign rs_dest_tag_o      = rob_tag_i;
assign reg_status_waddr_o = dec_rd;
assign reg_status_tag_o   = rob_tag_i;

// slot 1 sources written by slot 0 wait on slot 0's tag
always_comb begin
	rs_opnd_o       = disp_opnd;
	rs_opnd_ready_o = disp_ready;
	rs_opnd_tag_o   = disp_tag;
	if (dec_rd[0] != '0 && dec_rd[0] == dec_rs[1]) begin
		rs_opnd_ready_o[1][0] = 1'b0;
		rs_opnd_tag_o[1][0]   = rob_tag_i[0];
	end
	if (dec_rd[0] != '0 && dec_rd[0] == dec_rt[1] && !dec_use_imm[1]) begin
		rs_opnd_ready_o[1][1] = 1'b0;
		rs_opnd_tag_o[1][1]   = rob_tag_i[0];
	end
end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                       clk,
	input  logic                       reset_i,
	input  core_pkg::reg_addr_t  [3:0] raddr_i,
	output core_pkg::uint32_t    [3:0] rdata_o,
	output logic                 [3:0] busy_o,
	output core_pkg::rob_index_t [3:0] tag_o,
	input  logic                 [1:0] status_we_i,
	input  core_pkg::reg_addr_t  [1:0] status_waddr_i,
	input  core_pkg::rob_index_t [1:0] status_tag_i,
	input  logic                       commit_valid_i,
	input  core_pkg::reg_addr_t        commit_rd_i,
	input  core_pkg::rob_index_t       commit_tag_i,
	input  core_pkg::uint32_t          commit_data_i
);

core_pkg::uint32_t    regs [32];
logic          [31:0] busy;
core_pkg::rob_index_t tag  [32];

always_comb begin
	for (int i = 0; i < 4; i++) begin
		rdata_o[i] = (raddr_i[i] == '0) ? '0 : regs[raddr_i[i]];
		busy_o[i]  = busy[raddr_i[i]];
		tag_o[i]   = tag[raddr_i[i]];
	end
end

always_ff @(posedge clk) begin
	if (reset_i) begin
		busy <= '0;
		for (int i = 0; i < 32; i++) begin
			regs[i] <= '0;
		end
	end else begin
		if (commit_valid_i && commit_rd_i != '0) begin
			regs[commit_rd_i] <= commit_data_i;
			// a later writer keeps the register busy
			if (tag[commit_rd_i] == commit_tag_i) busy[commit_rd_i] <= 1'b0;
		end
		for (int w = 0; w < 2; w++) begin
			if (status_we_i[w] && status_waddr_i[w] != '0) busy[status_waddr_i[w]] <= 1'b1;
		end
	end
end

// slot 1 comes last so it wins on the same register
always_ff @(posedge clk) begin
	for (int w = 0; w < 2; w++) begin
		if (status_we_i[w] && status_waddr_i[w] != '0) tag[status_waddr_i[w]] <= status_tag_i[w];
	end
end

endmodule

`default_nettype wire

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                 [1:0] alloc_i,
	input  core_pkg::reg_addr_t  [1:0] alloc_rd_i,
	output logic                 [3:0] free_count_o,
	output core_pkg::rob_index_t [1:0] next_tag_o,
	input  core_pkg::rob_index_t [3:0] query_tag_i,
	output logic                 [3:0] query_ready_o,
	output core_pkg::uint32_t    [3:0] query_data_o,
	input  logic                       cdb_valid_i,
	input  core_pkg::rob_index_t       cdb_tag_i,
	input  core_pkg::uint32_t          cdb_data_i,
	output logic                       commit_valid_o,
	output core_pkg::reg_addr_t        commit_rd_o,
	output core_pkg::rob_index_t       commit_tag_o,
	output core_pkg::uint32_t          commit_data_o
);

core_pkg::rob_index_t           head;
core_pkg::rob_index_t           tail;
logic                     [3:0] count;
logic [core_pkg::ROB_DEPTH-1:0] done;
core_pkg::reg_addr_t            rd   [core_pkg::ROB_DEPTH];
core_pkg::uint32_t              data [core_pkg::ROB_DEPTH];
logic                           head_ready;

assign next_tag_o[0] = tail;
assign next_tag_o[1] = tail + 3'd1;
assign free_count_o  = 4'(core_pkg::ROB_DEPTH) - count;

// head result may still be on the cdb
assign head_ready = (count != '0) && (done[head] || (cdb_valid_i && cdb_tag_i == head));

// done stays set after commit until the tag is reused
always_comb begin
	for (int q = 0; q < 4; q++) begin
		query_ready_o[q] = done[query_tag_i[q]];
		query_data_o[q]  = data[query_tag_i[q]];
	end
end

always_ff @(posedge clk) begin
	if (reset_i) begin
		head           <= '0;
		tail           <= '0;
		count          <= '0;
		done           <= '0;
		commit_valid_o <= 1'b0;
	end else begin
		commit_valid_o <= head_ready;
		if (head_ready) head <= head + 3'd1;
		tail  <= tail + core_pkg::rob_index_t'({1'b0, alloc_i[0]} + {1'b0, alloc_i[1]});
		count <= count + {3'b0, alloc_i[0]} + {3'b0, alloc_i[1]} - {3'b0, head_ready};
		if (cdb_valid_i) done[cdb_tag_i] <= 1'b1;
		for (int w = 0; w < 2; w++) begin
			if (alloc_i[w]) done[tail + core_pkg::rob_index_t'(w)] <= 1'b0;
		end
	end
end

always_ff @(posedge clk) begin
	commit_rd_o   <= rd[head];
	commit_tag_o  <= head;
	commit_data_o <= done[head] ? data[head] : cdb_data_i;
	if (cdb_valid_i) data[cdb_tag_i] <= cdb_data_i;
	for (int w = 0; w < 2; w++) begin
		if (alloc_i[w]) rd[tail + core_pkg::rob_index_t'(w)] <= alloc_rd_i[w];
	end
end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the core testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_core -f src.f -o Vtb_core > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

// ==== src.f ====
rtl/core_pkg.sv
rtl/decoder.sv
rtl/dispatcher.sv
rtl/instr_issue.sv
rtl/reg_file.sv
rtl/alu_station.sv
rtl/reorder_buffer.sv
rtl/core_top.sv
bench/tb_core.sv
